// File: hw/game_rules_pkg.sv
package game_rules_pkg;

	// lives granted at game start and after game over
	localparam logic [3:0] life_init_default = 4'd3;

	// good obstacle hits that finish one level
	localparam logic [3:0] goals_per_level_default = 4'd2;

	// score, level and life all share this width
	typedef logic [3:0] counter_t;

	// idle waits for start
	// ready and game_over hold the level in reset until a key press
	typedef enum logic [2:0] {
		idle,
		ready,
		play,
		game_over
	} game_state_t;

endpackage

// File: hw/video_event_pkg.sv
package video_event_pkg;

	// draw requests of the sprite renderers for the current pixel
	typedef struct packed {
		logic smiley;		// smiley sprite covers this pixel
		logic border_bottom;	// bottom border covers this pixel
		logic obstacle;		// any obstacle covers this pixel
		logic obstacle_good;	// only meaningful with obstacle set
	} draw_req_t;

	// what the smiley touched during one whole frame
	typedef struct packed {
		logic hit_bottom;
		logic hit_obstacle;
		logic obstacle_good;	// set together with hit_obstacle for a good obstacle
	} collision_event_t;

endpackage

// File: hw/collision_detector.sv
`timescale 1ns/100ps

module collision_detector (
	input	logic					clk,
	input	logic					resetN,
	input	video_event_pkg::draw_req_t		pixel,
	input	logic					frame_start,
	output	logic					push,
	output	video_event_pkg::collision_event_t	push_event
);

	video_event_pkg::collision_event_t	pix_hit;	// overlaps of this pixel alone
	video_event_pkg::collision_event_t	frame_hit;	// sticky over the running frame

	// smiley has to be drawn on the same pixel as the other object
	always_comb begin
		pix_hit.hit_bottom    = pixel.smiley & pixel.border_bottom;
		pix_hit.hit_obstacle  = pixel.smiley & pixel.obstacle;
		pix_hit.obstacle_good = pixel.smiley & pixel.obstacle & pixel.obstacle_good;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frame_hit <= '0;
			push <= 1'b0;
		end else if (frame_start) begin
			push <= |frame_hit;		// only frames with an overlap make an event
			frame_hit <= pix_hit;		// first pixel already belongs to the new frame
		end else begin
			push <= 1'b0;
			frame_hit <= frame_hit | pix_hit;
		end
	end

	// event payload, only looked at together with push
	always_ff @(posedge clk) begin
		if (frame_start)
			push_event <= frame_hit;
	end

	// a good hit without an obstacle hit would be read as a bad one downstream
	a_good_has_obstacle: assert property (@(posedge clk) disable iff (!resetN)
		push |-> (push_event.hit_obstacle || !push_event.obstacle_good));

endmodule

// File: hw/event_queue.sv
`timescale 1ns/100ps

module event_queue #(
	parameter int depth = 4
) (
	input	logic					clk,
	input	logic					resetN,
	input	logic					push,
	input	video_event_pkg::collision_event_t	push_event,
	input	logic					pop,
	input	logic					flush,
	output	video_event_pkg::collision_event_t	head,
	output	logic					empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	video_event_pkg::collision_event_t	mem [depth];

	logic [ptr_w-1:0]	wr_ptr;
	logic [ptr_w-1:0]	rd_ptr;
	logic [cnt_w-1:0]	count;
	logic			full;
	logic			do_push;
	logic			do_pop;

	// wraps at depth so any depth works, not only powers of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == cnt_w'(depth));
	assign do_push = push && !full;		// event is lost when full
	assign do_pop = pop && !empty;
	assign head = mem[rd_ptr];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			// flush beats a push in the same cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_event;
	end

	// one event per frame cannot fill the queue unless something is stuck
	a_no_push_full: assert property (@(posedge clk) disable iff (!resetN)
		(push && !flush) |-> !full);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!resetN)
		pop |-> !empty);

endmodule

// File: hw/game_controller.sv
`timescale 1ns/100ps

module game_controller #(
	parameter game_rules_pkg::counter_t life_init = game_rules_pkg::life_init_default,
	parameter game_rules_pkg::counter_t goals_per_level = game_rules_pkg::goals_per_level_default
) (
	input	logic					clk,
	input	logic					resetN,
	input	logic					start,
	input	logic					key_press,
	input	video_event_pkg::collision_event_t	head,
	input	logic					empty,
	output	logic					pop,
	output	logic					pause,
	output	logic					reset_level,
	output	logic					reset_level_pulse,
	output	game_rules_pkg::counter_t		score,
	output	game_rules_pkg::counter_t		level,
	output	game_rules_pkg::counter_t		life
);

	game_rules_pkg::game_state_t	state;
	game_rules_pkg::game_state_t	state_next;
	game_rules_pkg::counter_t	score_next;
	game_rules_pkg::counter_t	level_next;
	game_rules_pkg::counter_t	life_next;
	logic				reset_level_d;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= game_rules_pkg::idle;
			score <= '0;
			level <= '0;
			life <= life_init;
			reset_level_d <= 1'b0;
		end else begin
			state <= state_next;
			score <= score_next;
			level <= level_next;
			life <= life_next;
			reset_level_d <= reset_level;
		end
	end

	// rising edge of reset_level, also flushes the event queue
	assign reset_level_pulse = reset_level && !reset_level_d;

	always_comb begin
		state_next = state;
		score_next = score;
		level_next = level;
		life_next = life;
		pause = 1'b1;
		reset_level = 1'b0;
		pop = 1'b0;

		case (state)
			game_rules_pkg::idle: begin
				if (start)
					state_next = game_rules_pkg::ready;
			end

			game_rules_pkg::ready: begin
				score_next = '0;
				reset_level = 1'b1;
				if (key_press)
					state_next = game_rules_pkg::play;
			end

			game_rules_pkg::play: begin
				pause = 1'b0;
				pop = !empty;		// one event per cycle, taken right away
				if (!empty) begin
					if (head.hit_bottom) begin
						life_next = life - 1'b1;
						if (life_next == '0)
							state_next = game_rules_pkg::game_over;
						else
							state_next = game_rules_pkg::ready;
					end else if (head.hit_obstacle && head.obstacle_good) begin
						if (score + 1'b1 == goals_per_level) begin
							// level done
							score_next = '0;
							level_next = level + 1'b1;
							state_next = game_rules_pkg::ready;
						end else begin
							score_next = score + 1'b1;
						end
					end
					// bad obstacle leaves everything as is
				end
			end

			game_rules_pkg::game_over: begin
				score_next = '0;
				level_next = '0;
				life_next = life_init;
				reset_level = 1'b1;
				if (key_press)
					state_next = game_rules_pkg::play;
			end

			default: begin
				state_next = game_rules_pkg::idle;
			end
		endcase
	end

	// the last life always ends in game_over before play can see zero
	a_life_in_play: assert property (@(posedge clk) disable iff (!resetN)
		(state == game_rules_pkg::play) |-> (life != '0));

	a_pop_in_play: assert property (@(posedge clk) disable iff (!resetN)
		pop |-> (state == game_rules_pkg::play));

endmodule

// File: hw/game_core.sv
`timescale 1ns/100ps

module game_core #(
	parameter int depth = 4,
	parameter game_rules_pkg::counter_t life_init = game_rules_pkg::life_init_default,
	parameter game_rules_pkg::counter_t goals_per_level = game_rules_pkg::goals_per_level_default
) (
	input	logic				clk,
	input	logic				resetN,
	input	video_event_pkg::draw_req_t	pixel,
	input	logic				frame_start,
	input	logic				start,
	input	logic				key_press,
	output	logic				pause,
	output	logic				reset_level,
	output	logic				reset_level_pulse,
	output	game_rules_pkg::counter_t	score,
	output	game_rules_pkg::counter_t	level,
	output	game_rules_pkg::counter_t	life
);

	logic					push;
	video_event_pkg::collision_event_t	push_event;
	video_event_pkg::collision_event_t	head;
	logic					empty;
	logic					pop;

	collision_detector collision_detector_i (
		.clk		(clk),
		.resetN		(resetN),
		.pixel		(pixel),
		.frame_start	(frame_start),
		.push		(push),
		.push_event	(push_event)
	);

	event_queue #(
		.depth		(depth)
	) event_queue_i (
		.clk		(clk),
		.resetN		(resetN),
		.push		(push),
		.push_event	(push_event),
		.pop		(pop),
		.flush		(reset_level_pulse),	// stale events die with each level reset
		.head		(head),
		.empty		(empty)
	);

	game_controller #(
		.life_init		(life_init),
		.goals_per_level	(goals_per_level)
	) game_controller_i (
		.clk			(clk),
		.resetN			(resetN),
		.start			(start),
		.key_press		(key_press),
		.head			(head),
		.empty			(empty),
		.pop			(pop),
		.pause			(pause),
		.reset_level		(reset_level),
		.reset_level_pulse	(reset_level_pulse),
		.score			(score),
		.level			(level),
		.life			(life)
	);

endmodule

// File: tb/game_core_tb.sv
`timescale 1ns/100ps

module game_core_tb;

	logic				clk;
	logic				resetN;
	video_event_pkg::draw_req_t	pixel;
	logic				frame_start;
	logic				start;
	logic				key_press;
	logic				pause;
	logic				reset_level;
	logic				reset_level_pulse;
	game_rules_pkg::counter_t	score;
	game_rules_pkg::counter_t	level;
	game_rules_pkg::counter_t	life;

	integer		seed;
	integer		fd;
	logic		start_level;	// start is a level and stays high once raised
	integer		cycle_count;
	integer		fs_cycle;	// monitor cycle that saw the last frame_start
	integer		latency_seen;
	integer		pulse_total;
	integer		pulse_mark;
	logic [11:0]	prev_counts;

	game_core dut_i (
		.clk			(clk),
		.resetN			(resetN),
		.pixel			(pixel),
		.frame_start		(frame_start),
		.start			(start),
		.key_press		(key_press),
		.pause			(pause),
		.reset_level		(reset_level),
		.reset_level_pulse	(reset_level_pulse),
		.score			(score),
		.level			(level),
		.life			(life)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// values read here are the ones from before this edge
	always @(posedge clk) begin
		if (!resetN) begin
			prev_counts = {score, level, life};
		end else begin
			cycle_count = cycle_count + 1;
			if (frame_start)
				fs_cycle = cycle_count;
			if ({score, level, life} != prev_counts) begin
				// change seen one edge after the one that made it
				latency_seen = cycle_count - fs_cycle - 1;
				prev_counts = {score, level, life};
			end
			if (reset_level_pulse)
				pulse_total = pulse_total + 1;
		end
	end

	task automatic abort_run(input string reason);
		$display("%0s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input string what,
			input integer expected, input integer actual);
		if (expected !== actual)
			abort_run($sformatf("[FAIL] %0s %0s: expected %0d, actual %0d",
				test, what, expected, actual));
	endtask

	// random filler that never shows the smiley
	function automatic video_event_pkg::draw_req_t background_pixel();
		integer r;
		video_event_pkg::draw_req_t px;
		r = $random(seed);
		px = r[3:0];
		px.smiley = 1'b0;
		return px;
	endfunction

	// drives one clock of inputs and returns at the falling edge where outputs are settled
	task automatic drive_cycle(input video_event_pkg::draw_req_t px, input logic fs,
			input logic kp);
		@(posedge clk);
		pixel <= px;
		frame_start <= fs;
		start <= start_level;
		key_press <= kp;
		@(negedge clk);
	endtask

	task automatic send_frame(input integer pixels, input integer bottom_idx,
			input integer good_idx, input integer bad_idx);
		video_event_pkg::draw_req_t px;
		for (int i = 0; i < pixels; i++) begin
			if (i == bottom_idx || i == good_idx || i == bad_idx) begin
				px = '0;
				px.smiley = 1'b1;
				px.border_bottom = (i == bottom_idx);
				px.obstacle = (i == good_idx) || (i == bad_idx);
				px.obstacle_good = (i == good_idx);
			end else begin
				px = background_pixel();
			end
			drive_cycle(px, i == 0, 1'b0);
		end
	endtask

	task automatic wait_pause(input string test, input integer value, input integer limit);
		integer waited;
		waited = 0;
		while (pause !== value[0]) begin
			if (waited >= limit) begin
				abort_run($sformatf("timeout in %0s: pause did not become %0d within %0d cycles",
					test, value, limit));
			end else begin
				drive_cycle(background_pixel(), 1'b0, 1'b0);
				waited = waited + 1;
			end
		end
	endtask

	task automatic run_stimulus();
		reg [8*16-1:0]	op;
		reg [8*32-1:0]	name;
		reg [8*256-1:0]	rest;
		string		test_name;
		integer		n;
		integer		v1;
		integer		v2;
		integer		v3;
		integer		v4;
		while ($fscanf(fd, "%s", op) == 1) begin
			case (op)
				"#": n = $fgets(rest, fd);	// comment line
				"frame": begin
					n = $fscanf(fd, "%d %d %d %d", v1, v2, v3, v4);
					if (n != 4)
						abort_run("stimulus file has a broken frame line");
					else
						send_frame(v1, v2, v3, v4);
				end
				"start": begin
					start_level = 1'b1;
					drive_cycle(background_pixel(), 1'b0, 1'b0);
				end
				"key": begin
					drive_cycle(background_pixel(), 1'b0, 1'b1);
					drive_cycle(background_pixel(), 1'b0, 1'b0);
				end
				"idle": begin
					n = $fscanf(fd, "%d", v1);
					if (n != 1)
						abort_run("stimulus file has a broken idle line");
					else
						repeat (v1) drive_cycle(background_pixel(), 1'b0, 1'b0);
				end
				"check": begin
					n = $fscanf(fd, "%s %d %d %d %d", name, v1, v2, v3, v4);
					test_name = $sformatf("%0s", name);
					if (n != 5) begin
						abort_run("stimulus file has a broken check line");
					end else begin
						check_value(test_name, "pause", v1, pause);
						// high in ready and game_over, so paused once start has left idle
						check_value(test_name, "reset_level", (v1 != 0) && start_level,
							reset_level);
						check_value(test_name, "score", v2, score);
						check_value(test_name, "level", v3, level);
						check_value(test_name, "life", v4, life);
					end
				end
				"wait_pause": begin
					n = $fscanf(fd, "%s %d %d", name, v1, v2);
					test_name = $sformatf("%0s", name);
					if (n != 3)
						abort_run("stimulus file has a broken wait_pause line");
					else
						wait_pause(test_name, v1, v2);
				end
				"latency": begin
					n = $fscanf(fd, "%s %d", name, v1);
					test_name = $sformatf("%0s", name);
					if (n != 2)
						abort_run("stimulus file has a broken latency line");
					else
						check_value(test_name, "latency", v1, latency_seen);
				end
				"pulses": begin
					n = $fscanf(fd, "%s %d", name, v1);
					test_name = $sformatf("%0s", name);
					if (n != 2) begin
						abort_run("stimulus file has a broken pulses line");
					end else begin
						check_value(test_name, "pulses", v1, pulse_total - pulse_mark);
						pulse_mark = pulse_total;
					end
				end
				default: abort_run($sformatf("unknown command %0s in stimulus file", op));
			endcase
		end
	endtask

	initial begin
		seed = 97;
		cycle_count = 0;
		fs_cycle = 0;
		latency_seen = 0;
		pulse_total = 0;
		pulse_mark = 0;
		start_level = 1'b0;
		resetN = 1'b0;
		pixel = '0;
		frame_start = 1'b0;
		start = 1'b0;
		key_press = 1'b0;
		repeat (4) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);
		fd = $fopen("tb/game_stim.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the stimulus file tb/game_stim.txt");
		end else begin
			run_stimulus();
			$fclose(fd);
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: tb/game_stim.txt
# frame <pixels> <bottom_idx> <good_idx> <bad_idx> (-1 = none) | start | key | idle <cycles>
# check <name> <pause> <score> <level> <life> | wait_pause <name> <pause> <limit> | latency <name> <cycles> | pulses <name> <count>
check after_reset 1 0 0 3
pulses after_reset 0
# overlaps made in idle are flushed when the game enters ready
frame 16 -1 5 -1
frame 16 -1 -1 3
frame 16 7 -1 -1
frame 16 -1 -1 -1
idle 4
check idle_hold 1 0 0 3
start
idle 2
check ready 1 0 0 3
pulses ready 1
key
wait_pause resume_first 0 10
check play_first 0 0 0 3
# good hit counts two cycles after the next frame start
frame 16 -1 4 -1
frame 16 -1 -1 -1
check good_hit 0 1 0 3
latency good_hit 2
frame 16 -1 -1 9
frame 16 -1 -1 -1
check bad_hit 0 1 0 3
# second good hit, placed on the frame start pixel
frame 16 -1 0 -1
frame 16 -1 -1 -1
check level_up 1 0 1 3
latency level_up 2
pulses level_up 1
key
wait_pause resume_level 0 10
check play_level 0 0 1 3
frame 20 2 -1 -1
frame 16 -1 -1 -1
check bottom_one 1 0 1 2
latency bottom_one 2
key
wait_pause resume_bottom_one 0 10
frame 20 12 -1 -1
frame 16 -1 -1 -1
check bottom_two 1 0 1 1
key
wait_pause resume_bottom_two 0 10
frame 20 6 -1 -1
frame 16 -1 -1 -1
check game_over 1 0 0 3
pulses bottom_hits 3
key
wait_pause resume_over 0 10
check play_over 0 0 0 3
# bottom, good and bad overlaps in one frame give one event
frame 24 3 8 11
frame 16 -1 -1 -1
check multi 1 0 0 2
latency multi 2
pulses multi 1
key
wait_pause resume_multi 0 10
frame 16 -1 6 -1
frame 16 -1 -1 -1
check after_multi 0 1 0 2

// File: compile.f
hw/game_rules_pkg.sv
hw/video_event_pkg.sv
hw/collision_detector.sv
hw/event_queue.sv
hw/game_controller.sv
hw/game_core.sv
tb/game_core_tb.sv

// File: Bender.yml
package:
  name: game_core

sources:
  - files:
      - hw/game_rules_pkg.sv
      - hw/video_event_pkg.sv
      - hw/collision_detector.sv
      - hw/event_queue.sv
      - hw/game_controller.sv
      - hw/game_core.sv
  - target: test
    files:
      - tb/game_core_tb.sv
